// File: Bender.yml
package:
  name: rv32_decode

sources:
  - src/rv32_pkg.sv
  - src/rv32_decode_ctrl.sv
  - src/rv32_imm_gen.sv
  - src/rv32_regs.sv
  - src/rv32_decode.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/rv32_decode_tb.sv

// File: rv32_decode.f
+incdir+test
src/rv32_pkg.sv
src/rv32_decode_ctrl.sv
src/rv32_imm_gen.sv
src/rv32_regs.sv
src/rv32_decode.sv
test/rv32_decode_tb.sv

// File: src/rv32_decode.sv
`timescale 1ns/1ps

module rv32_decode import rv32_pkg::*; #(
    parameter int unsigned num_regs = 32
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [xlen-1:0] pc_i,
    input  instr_t          instr_i,
    input  wb_t             wb_i,
    output logic            valid_o,
    output ctrl_t           ctrl_o,
    output logic [xlen-1:0] pc_o,
    output logic [xlen-1:0] imm_o,
    output logic [xlen-1:0] rs1_value_o,
    output logic [xlen-1:0] rs2_value_o
);

    imm_fmt_e imm_fmt; // chosen by the decoder in the same cycle.

    rv32_decode_ctrl u_ctrl (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .pc_i      (pc_i),
        .instr_i   (instr_i),
        .imm_fmt_o (imm_fmt),
        .valid_o   (valid_o),
        .ctrl_o    (ctrl_o),
        .pc_o      (pc_o)
    );

    rv32_imm_gen u_imm_gen (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .instr_i   (instr_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm_o)
    );

    // the source fields are read for every encoding, legal or not.
    rv32_regs #(
        .num_regs (num_regs)
    ) u_regs (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rs1_i       (instr_i.rs1),
        .rs2_i       (instr_i.rs2),
        .wb_i        (wb_i),
        .rs1_value_o (rs1_value_o),
        .rs2_value_o (rs2_value_o)
    );

endmodule

// File: src/rv32_decode_ctrl.sv
`timescale 1ns/1ps

module rv32_decode_ctrl import rv32_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [xlen-1:0] pc_i,
    input  instr_t          instr_i,
    output imm_fmt_e        imm_fmt_o,
    output logic            valid_o,
    output ctrl_t           ctrl_o,
    output logic [xlen-1:0] pc_o
);

    ctrl_t ctrl_d;
    logic  legal;

    function automatic alu_op_e funct3_to_alu_op(logic [2:0] funct3);
        case (funct3)
            funct3_op_sll:     return alu_op_sll;
            funct3_op_slt:     return alu_op_slt;
            funct3_op_sltu:    return alu_op_sltu;
            funct3_op_xor:     return alu_op_xor;
            funct3_op_srl_sra: return alu_op_srl_sra;
            funct3_op_or:      return alu_op_or;
            funct3_op_and:     return alu_op_and;
            default:           return alu_op_add_sub;
        endcase
    endfunction

    // compares need a subtraction, add and shift take the alternate bit.
    function automatic logic funct3_to_sub_sra(logic [2:0] funct3, logic alt);
        case (funct3)
            funct3_op_slt, funct3_op_sltu:    return 1'b1;
            funct3_op_add_sub, funct3_op_srl_sra: return alt;
            default:                          return 1'b0;
        endcase
    endfunction

    always_comb begin
        ctrl_d    = '0;
        legal     = 1'b0;
        imm_fmt_o = imm_fmt_none;
        case (instr_i.opcode)
            opcode_lui: begin
                legal               = 1'b1;
                ctrl_d.alu_op       = alu_op_src2;
                ctrl_d.alu_src2     = alu_src2_imm;
                ctrl_d.rd_writeback = 1'b1;
                imm_fmt_o           = imm_fmt_u;
            end
            opcode_auipc: begin
                legal               = 1'b1;
                ctrl_d.alu_op       = alu_op_add_sub;
                ctrl_d.alu_src1     = alu_src1_pc;
                ctrl_d.alu_src2     = alu_src2_imm;
                ctrl_d.rd_writeback = 1'b1;
                imm_fmt_o           = imm_fmt_u;
            end
            opcode_jal, opcode_jalr: begin
                legal                = instr_i.opcode == opcode_jal ||
                                       instr_i.funct3 == funct3_jalr;
                ctrl_d.alu_op        = alu_op_src1_plus4; // link address is pc + 4.
                ctrl_d.alu_src1      = alu_src1_pc;
                ctrl_d.branch_op     = branch_op_always;
                ctrl_d.rd_writeback  = 1'b1;
                if (instr_i.opcode == opcode_jal) begin
                    ctrl_d.branch_pc_src = branch_pc_src_imm;
                    imm_fmt_o            = imm_fmt_j;
                end else begin
                    ctrl_d.branch_pc_src = branch_pc_src_reg;
                    imm_fmt_o            = imm_fmt_i;
                end
            end
            opcode_branch: begin
                legal                = 1'b1;
                ctrl_d.alu_sub_sra   = 1'b1;
                ctrl_d.alu_src1      = alu_src1_reg;
                ctrl_d.alu_src2      = alu_src2_reg;
                ctrl_d.branch_pc_src = branch_pc_src_imm;
                imm_fmt_o            = imm_fmt_b;
                case (instr_i.funct3)
                    funct3_beq, funct3_bne:   ctrl_d.alu_op = alu_op_add_sub;
                    funct3_blt, funct3_bge:   ctrl_d.alu_op = alu_op_slt;
                    funct3_bltu, funct3_bgeu: ctrl_d.alu_op = alu_op_sltu;
                    default:                  legal = 1'b0;
                endcase
                // beq and the greater-or-equal forms take the branch on a zero result.
                ctrl_d.branch_op = instr_i.funct3 inside {funct3_beq, funct3_bge, funct3_bgeu} ?
                                   branch_op_zero : branch_op_non_zero;
            end
            opcode_load, opcode_store: begin
                ctrl_d.alu_op   = alu_op_add_sub;
                ctrl_d.alu_src1 = alu_src1_reg;
                ctrl_d.alu_src2 = alu_src2_imm;
                if (instr_i.opcode == opcode_load) begin
                    legal = instr_i.funct3 inside
                            {funct3_lb, funct3_lh, funct3_lw, funct3_lbu, funct3_lhu};
                    ctrl_d.mem_read_en  = 1'b1;
                    ctrl_d.rd_writeback = 1'b1;
                    imm_fmt_o           = imm_fmt_i;
                end else begin
                    legal               = instr_i.funct3 inside {funct3_sb, funct3_sh, funct3_sw};
                    ctrl_d.mem_write_en = 1'b1;
                    imm_fmt_o           = imm_fmt_s;
                end
            end
            opcode_op_imm: begin
                legal               = 1'b1;
                ctrl_d.alu_op       = funct3_to_alu_op(instr_i.funct3);
                ctrl_d.alu_sub_sra  = funct3_to_sub_sra(instr_i.funct3,
                    instr_i.funct3 == funct3_op_srl_sra && instr_i.funct7 == funct7_sub_sra);
                ctrl_d.alu_src1     = alu_src1_reg;
                ctrl_d.alu_src2     = alu_src2_imm;
                ctrl_d.rd_writeback = 1'b1;
                imm_fmt_o           = imm_fmt_i;
                if (instr_i.funct3 == funct3_op_sll) begin
                    legal     = instr_i.funct7 == funct7_zero;
                    imm_fmt_o = imm_fmt_shamt;
                end else if (instr_i.funct3 == funct3_op_srl_sra) begin
                    legal     = instr_i.funct7 inside {funct7_zero, funct7_sub_sra};
                    imm_fmt_o = imm_fmt_shamt;
                end
            end
            opcode_op: begin
                legal = instr_i.funct7 == funct7_zero ||
                        (instr_i.funct7 == funct7_sub_sra &&
                         instr_i.funct3 inside {funct3_op_add_sub, funct3_op_srl_sra});
                ctrl_d.alu_op       = funct3_to_alu_op(instr_i.funct3);
                ctrl_d.alu_sub_sra  = funct3_to_sub_sra(instr_i.funct3,
                                                        instr_i.funct7 == funct7_sub_sra);
                ctrl_d.alu_src1     = alu_src1_reg;
                ctrl_d.alu_src2     = alu_src2_reg;
                ctrl_d.rd_writeback = 1'b1;
            end
            opcode_misc_mem: begin
                legal = instr_i.funct3 == funct3_fence; // fence.i has no cache to act on.
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        if (legal) begin
            ctrl_d.rd = instr_i.rd;
        end else begin
            ctrl_d    = '0;
            imm_fmt_o = imm_fmt_none;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            ctrl_o  <= '0;
        end else begin
            valid_o <= legal;
            ctrl_o  <= ctrl_d;
        end
    end

    always_ff @(posedge clk) begin
        pc_o <= pc_i;
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(ctrl_o.mem_read_en && ctrl_o.mem_write_en));

    a_invalid_no_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
        !valid_o |-> !ctrl_o.rd_writeback);

endmodule

// File: src/rv32_imm_gen.sv
`timescale 1ns/1ps

module rv32_imm_gen import rv32_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  instr_t          instr_i,
    input  imm_fmt_e        imm_fmt_i,
    output logic [xlen-1:0] imm_o
);

    logic [31:0]     w;
    logic [xlen-1:0] imm_d;

    assign w = instr_i;

    always_comb begin
        case (imm_fmt_i)
            rv32_pkg::imm_fmt_i: imm_d = {{21{w[31]}}, w[30:20]};
            imm_fmt_s:     imm_d = {{21{w[31]}}, w[30:25], w[11:7]};
            imm_fmt_b:     imm_d = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_fmt_u:     imm_d = {w[31:12], 12'b0};
            imm_fmt_j:     imm_d = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            imm_fmt_shamt: imm_d = {{(xlen - reg_addr_w){1'b0}}, instr_i.rs2};
            default:       imm_d = '0; // register-register ops and fence carry no immediate.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            imm_o <= '0;
        end else begin
            imm_o <= imm_d;
        end
    end

    // branch and jump targets are always halfword aligned.
    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        imm_fmt_i inside {imm_fmt_b, imm_fmt_j} |=> imm_o[0] == 1'b0);

endmodule

// File: src/rv32_pkg.sv
package rv32_pkg;

    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;

    // base opcodes of the rv32i set.
    localparam logic [6:0] opcode_lui      = 7'b0110111;
    localparam logic [6:0] opcode_auipc    = 7'b0010111;
    localparam logic [6:0] opcode_jal      = 7'b1101111;
    localparam logic [6:0] opcode_jalr     = 7'b1100111;
    localparam logic [6:0] opcode_branch   = 7'b1100011;
    localparam logic [6:0] opcode_load     = 7'b0000011;
    localparam logic [6:0] opcode_store    = 7'b0100011;
    localparam logic [6:0] opcode_op_imm   = 7'b0010011;
    localparam logic [6:0] opcode_op       = 7'b0110011;
    localparam logic [6:0] opcode_misc_mem = 7'b0001111;

    localparam logic [2:0] funct3_jalr = 3'b000;

    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_blt  = 3'b100;
    localparam logic [2:0] funct3_bge  = 3'b101;
    localparam logic [2:0] funct3_bltu = 3'b110;
    localparam logic [2:0] funct3_bgeu = 3'b111;

    localparam logic [2:0] funct3_lb  = 3'b000;
    localparam logic [2:0] funct3_lh  = 3'b001;
    localparam logic [2:0] funct3_lw  = 3'b010;
    localparam logic [2:0] funct3_lbu = 3'b100;
    localparam logic [2:0] funct3_lhu = 3'b101;

    localparam logic [2:0] funct3_sb = 3'b000;
    localparam logic [2:0] funct3_sh = 3'b001;
    localparam logic [2:0] funct3_sw = 3'b010;

    // shared by the register-immediate and register-register groups.
    localparam logic [2:0] funct3_op_add_sub = 3'b000;
    localparam logic [2:0] funct3_op_sll     = 3'b001;
    localparam logic [2:0] funct3_op_slt     = 3'b010;
    localparam logic [2:0] funct3_op_sltu    = 3'b011;
    localparam logic [2:0] funct3_op_xor     = 3'b100;
    localparam logic [2:0] funct3_op_srl_sra = 3'b101;
    localparam logic [2:0] funct3_op_or      = 3'b110;
    localparam logic [2:0] funct3_op_and     = 3'b111;

    localparam logic [2:0] funct3_fence = 3'b000;

    localparam logic [6:0] funct7_zero    = 7'b0000000;
    localparam logic [6:0] funct7_sub_sra = 7'b0100000;

    localparam logic alu_src1_reg      = 1'b0;
    localparam logic alu_src1_pc       = 1'b1;
    localparam logic alu_src2_reg      = 1'b0;
    localparam logic alu_src2_imm      = 1'b1;
    localparam logic branch_pc_src_imm = 1'b0;
    localparam logic branch_pc_src_reg = 1'b1;

    typedef enum logic [3:0] {
        alu_op_add_sub    = 4'd0,
        alu_op_xor        = 4'd1,
        alu_op_or         = 4'd2,
        alu_op_and        = 4'd3,
        alu_op_sll        = 4'd4,
        alu_op_srl_sra    = 4'd5,
        alu_op_slt        = 4'd6,
        alu_op_sltu       = 4'd7,
        alu_op_src2       = 4'd8,
        alu_op_src1_plus4 = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        branch_op_never    = 2'd0,
        branch_op_zero     = 2'd1,
        branch_op_non_zero = 2'd2,
        branch_op_always   = 2'd3
    } branch_op_e;

    typedef enum logic [2:0] {
        imm_fmt_none  = 3'd0,
        imm_fmt_i     = 3'd1,
        imm_fmt_s     = 3'd2,
        imm_fmt_b     = 3'd3,
        imm_fmt_u     = 3'd4,
        imm_fmt_j     = 3'd5,
        imm_fmt_shamt = 3'd6
    } imm_fmt_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } instr_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  alu_sub_sra;
        logic                  alu_src1;
        logic                  alu_src2;
        logic                  mem_read_en;
        logic                  mem_write_en;
        branch_op_e            branch_op;
        logic                  branch_pc_src;
        logic [reg_addr_w-1:0] rd;
        logic                  rd_writeback;
    } ctrl_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic                  en;
        logic [xlen-1:0]       value;
    } wb_t;

endpackage

// File: src/rv32_regs.sv
`timescale 1ns/1ps

module rv32_regs import rv32_pkg::*; #(
    parameter int unsigned num_regs = 32
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [reg_addr_w-1:0] rs1_i,
    input  logic [reg_addr_w-1:0] rs2_i,
    input  wb_t                   wb_i,
    output logic [xlen-1:0]       rs1_value_o,
    output logic [xlen-1:0]       rs2_value_o
);

    localparam int unsigned idx_w = $clog2(num_regs);

    logic [xlen-1:0] regs_q [num_regs];
    logic            wr_en;

    // indices above the implemented range are dropped on write.
    assign wr_en = wb_i.en && wb_i.rd != '0 && wb_i.rd < num_regs;

    function automatic logic [xlen-1:0] read_port(logic [reg_addr_w-1:0] addr);
        if (addr == '0 || addr >= num_regs) begin
            return '0;
        end
        if (wr_en && wb_i.rd == addr) begin
            return wb_i.value; // write in the same cycle wins.
        end
        return regs_q[addr[idx_w-1:0]];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd[idx_w-1:0]] <= wb_i.value;
        end
    end

    always_ff @(posedge clk) begin
        rs1_value_o <= read_port(rs1_i);
        rs2_value_o <= read_port(rs2_i);
    end

    a_x0_rs1: assert property (@(posedge clk) disable iff (!rst_n_i)
        rs1_i == '0 |=> rs1_value_o == '0);

    a_x0_rs2: assert property (@(posedge clk) disable iff (!rst_n_i)
        rs2_i == '0 |=> rs2_value_o == '0);

endmodule

// File: test/rv32_decode_ref.svh
`ifndef RV32_DECODE_REF_SVH
`define RV32_DECODE_REF_SVH

typedef struct packed {
    logic            valid;
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
} dec_exp_t;

alu_op_e funct3_alu [8] = '{alu_op_add_sub, alu_op_sll, alu_op_slt, alu_op_sltu,
                            alu_op_xor, alu_op_srl_sra, alu_op_or, alu_op_and};

logic [xlen-1:0] reg_model [32] = '{default: '0};

// x0 keeps its zero, every other enabled write lands in the model.
function automatic void model_write(wb_t wb);
    if (wb.en && wb.rd != 5'd0) begin
        reg_model[wb.rd] = wb.value;
    end
endfunction

function automatic dec_exp_t ref_decode(logic [31:0] w);
    dec_exp_t    e;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] imm_i;
    f3    = w[14:12];
    alt   = w[31:25] == 7'h20;
    imm_i = {{20{w[31]}}, w[31:20]};
    e       = '0;
    e.valid = 1'b1;
    case (w[6:0])
        opcode_lui, opcode_auipc: begin
            e.ctrl.alu_op   = w[5] ? alu_op_src2 : alu_op_add_sub; // bit 5 tells lui apart.
            e.ctrl.alu_src1 = !w[5];
            e.ctrl.alu_src2 = 1'b1;
            e.imm           = {w[31:12], 12'h000};
        end
        opcode_jal, opcode_jalr: begin
            e.valid              = w[3] || f3 == 3'd0; // bit 3 is set only for jal.
            e.ctrl.alu_op        = alu_op_src1_plus4;
            e.ctrl.alu_src1      = 1'b1;
            e.ctrl.branch_op     = branch_op_always;
            e.ctrl.branch_pc_src = !w[3];
            e.imm = w[3] ? {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0} : imm_i;
        end
        opcode_branch: begin
            e.valid            = f3[2:1] != 2'b01;
            e.ctrl.alu_op      = f3[2:1] == 2'b00 ? alu_op_add_sub :
                                 (f3[1] ? alu_op_sltu : alu_op_slt);
            e.ctrl.alu_sub_sra = 1'b1;
            e.ctrl.branch_op   = f3[0] == f3[2] ? branch_op_zero : branch_op_non_zero;
            e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        opcode_load: begin
            e.valid            = f3 != 3'd3 && f3 < 3'd6;
            e.ctrl.alu_src2    = 1'b1;
            e.ctrl.mem_read_en = 1'b1;
            e.imm              = imm_i;
        end
        opcode_store: begin
            e.valid             = f3 <= 3'd2;
            e.ctrl.alu_src2     = 1'b1;
            e.ctrl.mem_write_en = 1'b1;
            e.imm               = {{20{w[31]}}, w[31:25], w[11:7]};
        end
        opcode_op_imm, opcode_op: begin
            e.ctrl.alu_op   = funct3_alu[f3];
            e.ctrl.alu_src2 = !w[5];
            if (w[5]) begin
                e.valid            = w[31:25] == 7'h00 || (alt && (f3 == 3'd0 || f3 == 3'd5));
                e.ctrl.alu_sub_sra = f3[2:1] == 2'b01 || alt;
            end else begin
                e.valid            = f3[1:0] != 2'b01 || w[31:25] == 7'h00 || (f3[2] && alt);
                e.ctrl.alu_sub_sra = f3[2:1] == 2'b01 || (f3 == 3'd5 && alt);
                e.imm              = f3[1:0] == 2'b01 ? {27'd0, w[24:20]} : imm_i;
            end
        end
        opcode_misc_mem: e.valid = f3 == 3'd0;
        default:         e.valid = 1'b0;
    endcase
    if (e.valid) begin
        e.ctrl.rd           = w[11:7];
        e.ctrl.rd_writeback = !(w[6:0] inside {opcode_branch, opcode_store, opcode_misc_mem});
    end else begin
        e = '0;
    end
    return e;
endfunction

`endif

// File: test/rv32_decode_tb.sv
`timescale 1ns/1ps

module rv32_decode_tb import rv32_pkg::*; ();

    localparam int clk_period   = 40;
    localparam int n_reset      = 10;
    localparam int n_legal      = 600;
    localparam int n_illegal    = 120;
    localparam int n_bypass     = 100;
    localparam int total_cycles = n_reset + n_legal + n_illegal + n_bypass + 3;

    logic            clk;
    logic            rst_n_i;
    logic [xlen-1:0] pc_i;
    instr_t          instr_i;
    wb_t             wb_i;
    logic            valid_o;
    ctrl_t           ctrl_o;
    logic [xlen-1:0] pc_o;
    logic [xlen-1:0] imm_o;
    logic [xlen-1:0] rs1_value_o;
    logic [xlen-1:0] rs2_value_o;

`include "rv32_decode_ref.svh"

    typedef struct packed {
        dec_exp_t        dec;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
    } exp_t;

    exp_t exp_q [$];
    int   sent    = 0;
    int   checked = 0;

    rv32_decode uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .wb_i        (wb_i),
        .valid_o     (valid_o),
        .ctrl_o      (ctrl_o),
        .pc_o        (pc_o),
        .imm_o       (imm_o),
        .rs1_value_o (rs1_value_o),
        .rs2_value_o (rs2_value_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic check_value(string what, logic [63:0] got, logic [63:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic check_reset_state();
        check_value("valid_o after reset", valid_o, 1'b0);
        check_value("ctrl_o after reset", ctrl_o, '0);
        check_value("imm_o after reset", imm_o, '0);
    endtask

    task automatic compare_outputs(exp_t e);
        check_value("valid_o", valid_o, e.dec.valid);
        check_value("ctrl_o", ctrl_o, e.dec.ctrl);
        check_value("imm_o", imm_o, e.dec.imm);
        check_value("pc_o", pc_o, e.pc);
        check_value("rs1_value_o", rs1_value_o, e.rs1);
        check_value("rs2_value_o", rs2_value_o, e.rs2);
    endtask

    function automatic wb_t random_wb();
        wb_t wb;
        wb.rd    = $urandom_range(7, 0) == 0 ? 5'd0 : 5'($urandom_range(31, 1));
        wb.en    = $urandom_range(1, 0);
        wb.value = $urandom;
        return wb;
    endfunction

    function automatic logic [31:0] legal_instr(int cls);
        instr_t     i;
        logic [2:0] f;
        i = $urandom;
        f = $urandom;
        case (cls)
            0: i.opcode = opcode_lui;
            1: i.opcode = opcode_auipc;
            2: i.opcode = opcode_jal;
            3: i = '{funct7: i.funct7, rs2: i.rs2, rs1: i.rs1, funct3: 3'd0, rd: i.rd,
                     opcode: opcode_jalr};
            4: begin
                i.opcode = opcode_branch;
                i.funct3 = f[2:1] == 2'b01 ? f ^ 3'b110 : f; // 2 and 3 become 4 and 5.
            end
            5: begin
                i.opcode = opcode_load;
                i.funct3 = f == 3'd3 || f > 3'd5 ? 3'd2 : f;
            end
            6: begin
                i.opcode = opcode_store;
                i.funct3 = 3'($urandom_range(2, 0));
            end
            7: begin
                i.opcode = opcode_op_imm;
                if (i.funct3[1:0] == 2'b01) begin
                    i.funct7 = i.funct3[2] && f[0] ? funct7_sub_sra : funct7_zero;
                end
            end
            8: begin
                i.opcode = opcode_op;
                i.funct7 = f[0] ? funct7_sub_sra : funct7_zero;
                if (f[0]) begin
                    i.funct3 = f[1] ? 3'd5 : 3'd0;
                end
            end
            default: i = '{funct7: i.funct7, rs2: i.rs2, rs1: i.rs1, funct3: 3'd0, rd: i.rd,
                           opcode: opcode_misc_mem};
        endcase
        return i;
    endfunction

    function automatic logic [31:0] illegal_instr(int kind);
        instr_t i;
        i = $urandom;
        case (kind)
            0: do begin
                i.opcode = $urandom;
            end while (i.opcode inside {opcode_lui, opcode_auipc, opcode_jal, opcode_jalr,
                opcode_branch, opcode_load, opcode_store, opcode_op_imm, opcode_op,
                opcode_misc_mem});
            1: i = '{funct7: i.funct7, rs2: i.rs2, rs1: i.rs1,
                     funct3: 3'($urandom_range(7, 1)), rd: i.rd, opcode: opcode_jalr};
            2: begin
                i.opcode = opcode_op;
                while (i.funct7 inside {funct7_zero, funct7_sub_sra}) i.funct7 = $urandom;
            end
            3: begin
                i.opcode = opcode_op;
                i.funct7 = funct7_sub_sra;
                while (i.funct3 inside {3'd0, 3'd5}) i.funct3 = $urandom;
            end
            4: begin
                i.opcode = opcode_op_imm;
                i.funct3 = i.funct3[0] ? 3'd1 : 3'd5;
                while (i.funct7 == 7'h00 || (i.funct3 == 3'd5 && i.funct7 == 7'h20)) begin
                    i.funct7 = $urandom;
                end
            end
            default: i = '{funct7: i.funct7, rs2: i.rs2, rs1: i.rs1, funct3: 3'd1, rd: i.rd,
                           opcode: opcode_misc_mem}; // fence.i
        endcase
        return i;
    endfunction

    task automatic issue_instr(logic [31:0] word, wb_t wb);
        exp_t e;
        @(negedge clk);
        pc_i    = $urandom & 32'hffff_fffc;
        instr_i = word;
        wb_i    = wb;
        model_write(wb); // the read sees a write of the same edge.
        e.dec = ref_decode(word);
        e.pc  = pc_i;
        e.rs1 = reg_model[word[19:15]];
        e.rs2 = reg_model[word[24:20]];
        exp_q.push_back(e);
        sent++;
    endtask

    // outputs are taken at the falling edge, half a cycle after they settle.
    initial begin
        exp_t cur;
        logic have;
        forever begin
            @(posedge clk);
            have = exp_q.size() > 0;
            if (have) begin
                cur = exp_q.pop_front();
            end
            @(negedge clk);
            if (have) begin
                compare_outputs(cur);
                checked++;
            end
        end
    end

    initial begin
        logic [31:0] word;
        wb_t         wb;
        void'($urandom(76902));
        rst_n_i = 1'b0;
        pc_i    = '0;
        instr_i = '0;
        wb_i    = '0;
        repeat (n_reset) begin
            @(negedge clk);
            check_reset_state();
        end
        rst_n_i = 1'b1;
        @(negedge clk);
        check_reset_state();
        repeat (n_legal) begin
            issue_instr(legal_instr($urandom_range(9, 0)), random_wb());
        end
        for (int k = 0; k < n_illegal; k++) begin
            issue_instr(illegal_instr(k % 6), random_wb());
        end
        repeat (n_bypass) begin
            wb          = random_wb();
            wb.en       = 1'b1;
            word        = legal_instr($urandom_range(9, 0));
            word[19:15] = wb.rd;
            if ($urandom_range(1, 0) == 1) begin
                word[24:20] = wb.rd;
            end
            issue_instr(word, wb);
        end
        repeat (2) @(negedge clk);
        if (checked == sent && exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("ERROR: only %0d of %0d instructions were checked", checked, sent);
            $display("SIMULATION FAILED");
            $fatal(1, "incomplete run");
        end
    end

    initial begin
        #(clk_period * (total_cycles + 100));
        $display("ERROR: watchdog expired at %0t ns, the simulation hung", $time);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

endmodule
